// ==== src/muldiv_macros.svh ====
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// Width of one data word and of each half of HI/LO
`define MD_WORD_W 32

// Divide latency from start to final quotient and remainder
// One setup cycle, one shift step per quotient bit, one sign fix-up cycle
`define MD_DIV_CYC 34

// Multiply latency from issue to the HI/LO write
`define MD_MUL_CYC 2

`endif

// ==== src/muldiv_pkg.sv ====
`include "muldiv_macros.svh"

package muldiv_pkg;

	typedef logic [`MD_WORD_W-1:0]   word_t;   // One general register value
	typedef logic [2*`MD_WORD_W-1:0] dword_t;  // HI in the upper half, LO in the lower

	// Operations handled by the unit
	typedef enum logic [3:0] {
		MD_NOP   = 4'd0,
		MD_MULT  = 4'd1,
		MD_MULTU = 4'd2,
		MD_MADD  = 4'd3,
		MD_MADDU = 4'd4,
		MD_MSUB  = 4'd5,
		MD_MSUBU = 4'd6,
		MD_MUL   = 4'd7,   // Writes a general register, HI/LO untouched
		MD_DIV   = 4'd8,
		MD_DIVU  = 4'd9,
		MD_MFHI  = 4'd10,
		MD_MFLO  = 4'd11,
		MD_MTHI  = 4'd12,
		MD_MTLO  = 4'd13
	} md_op_t;

	// --------------------
	// R-type layout shared by SPECIAL and SPECIAL2
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [5:0] funct;
	} rtype_t;

	// --------------------
	// Decoded request, from decode to execute and to the HI/LO stage
	typedef struct packed {
		logic   valid;
		md_op_t op;
		word_t  a;       // Value of rs
		word_t  b;       // Value of rt
	} md_req_t;

	// Arithmetic result, from execute to the HI/LO stage
	typedef struct packed {
		logic   valid;
		logic   to_gpr;  // MUL result, goes to the register write port
		dword_t value;
	} md_res_t;

endpackage

// ==== src/md_decode.sv ====
module md_decode import muldiv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    flush,
	input  logic    instr_valid,
	input  word_t   instr,
	input  word_t   rs_data,
	input  word_t   rt_data,
	input  logic    busy,
	output md_req_t req
);

	localparam logic [5:0] OPC_SPECIAL  = 6'b000000;
	localparam logic [5:0] OPC_SPECIAL2 = 6'b011100;

	rtype_t fields;
	md_op_t op_dec;
	logic   valid_q;
	md_op_t op_q;
	word_t  a_q;
	word_t  b_q;

	assign fields = rtype_t'(instr);

	// Only these two major opcodes belong to the unit, sa must be zero for all of them
	always_comb
	begin
		op_dec = MD_NOP;
		if (fields.sa == 5'd0 && fields.opcode == OPC_SPECIAL)
		begin
			case (fields.funct)
				6'h10:   op_dec = MD_MFHI;
				6'h11:   op_dec = MD_MTHI;
				6'h12:   op_dec = MD_MFLO;
				6'h13:   op_dec = MD_MTLO;
				6'h18:   op_dec = MD_MULT;
				6'h19:   op_dec = MD_MULTU;
				6'h1a:   op_dec = MD_DIV;
				6'h1b:   op_dec = MD_DIVU;
				default: op_dec = MD_NOP;
			endcase
		end
		else if (fields.sa == 5'd0 && fields.opcode == OPC_SPECIAL2)
		begin
			case (fields.funct)
				6'h00:   op_dec = MD_MADD;
				6'h01:   op_dec = MD_MADDU;
				6'h02:   op_dec = MD_MUL;
				6'h04:   op_dec = MD_MSUB;
				6'h05:   op_dec = MD_MSUBU;
				default: op_dec = MD_NOP;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			valid_q <= 1'b0;
			op_q    <= MD_NOP;
		end
		else
		begin
			valid_q <= instr_valid && (op_dec != MD_NOP);  // Foreign opcodes are dropped here
			op_q    <= instr_valid ? op_dec : MD_NOP;
		end
	end

	always_ff @(posedge clk)
	begin
		a_q <= rs_data;
		b_q <= rt_data;
	end

	assign req = '{valid: valid_q, op: op_q, a: a_q, b: b_q};

	// The core holds off issue while a multiply or divide is still in flight
	issue_while_busy: assert property (@(posedge clk) disable iff (rst)
		!(instr_valid && busy))
		else $error("instruction issued while the unit is busy");

endmodule

// ==== src/md_divider.sv ====
`include "muldiv_macros.svh"

module md_divider import muldiv_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  flush,
	input  logic  start,
	input  word_t dividend,
	input  word_t divisor,
	output word_t quotient,
	output word_t remainder,
	output logic  done
);

	localparam int W     = `MD_WORD_W;
	localparam int STEPS = `MD_DIV_CYC - 2;  // Setup and sign fix-up take the other two
	localparam int CNT_W = $clog2(STEPS + 1);

	logic             running;
	logic             done_q;
	logic [CNT_W-1:0] count;
	word_t            quo;                   // Dividend bits shift out, quotient bits shift in
	word_t            rem;                   // Partial remainder
	word_t            dvs;
	logic [W:0]       partial;
	logic [W:0]       diff;

	assign partial = {rem, quo[W-1]};
	assign diff    = partial - {1'b0, dvs};  // Top bit set means the trial subtract borrowed

	// --------------------
	// Step counter
	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			running <= 1'b0;
			done_q  <= 1'b0;
			count   <= '0;
		end
		else
		begin
			done_q <= 1'b0;
			if (start)
			begin
				running <= 1'b1;
				count   <= CNT_W'(STEPS);
			end
			else if (running)
			begin
				count <= count - 1'b1;
				if (count == CNT_W'(1))
				begin
					running <= 1'b0;
					done_q  <= 1'b1;   // Last quotient bit lands on this edge
				end
			end
		end
	end

	// --------------------
	// Restoring shift and subtract
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			quo <= dividend;
			rem <= '0;
			dvs <= divisor;
		end
		else if (running)
		begin
			if (!diff[W])
			begin
				rem <= diff[W-1:0];
				quo <= {quo[W-2:0], 1'b1};
			end
			else
			begin
				rem <= partial[W-1:0];  // Restore, the divisor did not fit
				quo <= {quo[W-2:0], 1'b0};
			end
		end
	end

	assign quotient  = quo;
	assign remainder = rem;
	assign done      = done_q;

	no_restart: assert property (@(posedge clk) disable iff (rst)
		start |-> !(running || done_q))
		else $error("divider started while a divide is in progress");

endmodule

// ==== src/md_execute.sv ====
`include "muldiv_macros.svh"

module md_execute import muldiv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    flush,
	input  md_req_t req,
	input  dword_t  hilo,
	output md_res_t res,
	output logic    busy
);

	localparam int W    = `MD_WORD_W;
	localparam int HALF = W / 2;

	logic         is_signed;
	logic         is_mul_op;
	logic         is_div_op;
	logic         sign_a;
	logic         sign_b;
	word_t        abs_a;
	word_t        abs_b;
	word_t        p_hh;
	word_t        p_hl;
	word_t        p_lh;
	word_t        p_ll;
	logic         mul_valid;
	md_op_t       mul_op;
	logic         mul_neg;
	word_t        pp_hi;
	logic [W:0]   pp_md;          // Sum of the two cross products with one carry bit
	word_t        pp_lo;
	dword_t       mul_abs;
	dword_t       mul_prod;
	dword_t       mul_value;
	logic         div_start;
	logic         div_busy;
	logic         div_valid;
	logic         div_neg_q;
	logic         div_neg_r;
	word_t        abs_quo;
	word_t        abs_rem;
	logic         div_done;
	dword_t       div_value;

	assign is_signed = req.op inside {MD_MULT, MD_MADD, MD_MSUB, MD_MUL, MD_DIV};
	assign is_mul_op = req.op inside {MD_MULT, MD_MULTU, MD_MADD, MD_MADDU,
		MD_MSUB, MD_MSUBU, MD_MUL};
	assign is_div_op = req.op inside {MD_DIV, MD_DIVU};

	assign sign_a = is_signed && req.a[W-1];
	assign sign_b = is_signed && req.b[W-1];
	assign abs_a  = sign_a ? -req.a : req.a;
	assign abs_b  = sign_b ? -req.b : req.b;

	// --------------------
	// Multiply with the partial products in one register stage
	assign p_hh = abs_a[W-1:HALF] * abs_b[W-1:HALF];
	assign p_hl = abs_a[W-1:HALF] * abs_b[HALF-1:0];
	assign p_lh = abs_a[HALF-1:0] * abs_b[W-1:HALF];
	assign p_ll = abs_a[HALF-1:0] * abs_b[HALF-1:0];

	always_ff @(posedge clk)
	begin
		if (rst || flush)
			mul_valid <= 1'b0;
		else
			mul_valid <= req.valid && is_mul_op;
	end

	always_ff @(posedge clk)
	begin
		mul_op  <= req.op;
		mul_neg <= sign_a ^ sign_b;
		pp_hi   <= p_hh;
		pp_md   <= {1'b0, p_hl} + {1'b0, p_lh};
		pp_lo   <= p_ll;
	end

	assign mul_abs  = {pp_hi, pp_lo} + {{(HALF - 1){1'b0}}, pp_md, {HALF{1'b0}}};
	assign mul_prod = mul_neg ? -mul_abs : mul_abs;

	always_comb
	begin
		case (mul_op)
			MD_MADD, MD_MADDU: mul_value = hilo + mul_prod;
			MD_MSUB, MD_MSUBU: mul_value = hilo - mul_prod;
			default:           mul_value = mul_prod;  // MULT, MULTU and MUL
		endcase
	end

	// --------------------
	// Divide on magnitudes with the signs restored afterwards
	assign div_start = req.valid && is_div_op;

	md_divider md_divider_i (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.start     (div_start),
		.dividend  (abs_a),
		.divisor   (abs_b),
		.quotient  (abs_quo),
		.remainder (abs_rem),
		.done      (div_done)
	);

	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			div_valid <= 1'b0;
			div_busy  <= 1'b0;
		end
		else
		begin
			div_valid <= div_done;
			if (div_valid)
				div_busy <= 1'b0;   // Drops together with the HI/LO write
			else if (div_start)
				div_busy <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (div_start)
		begin
			div_neg_q <= sign_a ^ sign_b;
			div_neg_r <= sign_a;           // Remainder follows the dividend
		end
		if (div_done)
			div_value <= {div_neg_r ? -abs_rem : abs_rem, div_neg_q ? -abs_quo : abs_quo};
	end

	assign res = '{
		valid:  mul_valid || div_valid,
		to_gpr: mul_valid && (mul_op == MD_MUL),
		value:  div_valid ? div_value : mul_value
	};

	assign busy = div_busy || (req.valid && (is_mul_op || is_div_op));

	result_vs_request: assert property (@(posedge clk) disable iff (rst)
		!(res.valid && req.valid))
		else $error("result collides with a new request");

	// A multiply result never shares its slot with a divide result
	mul_slot_free: assert property (@(posedge clk) disable iff (rst || flush)
		(req.valid && is_mul_op) |-> ##(`MD_MUL_CYC - 1) !div_valid)
		else $error("divide result lands on a multiply result");

endmodule

// ==== src/md_hilo.sv ====
`include "muldiv_macros.svh"

module md_hilo import muldiv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  md_req_t req,
	input  md_res_t res,
	output dword_t  hilo,
	output logic    gpr_we,
	output word_t   gpr_data
);

	localparam int W = `MD_WORD_W;

	dword_t hilo_q;
	logic   we_q;
	word_t  data_q;
	logic   is_mfhi;
	logic   is_mflo;
	logic   mul_to_gpr;

	assign is_mfhi    = req.valid && (req.op == MD_MFHI);
	assign is_mflo    = req.valid && (req.op == MD_MFLO);
	assign mul_to_gpr = res.valid && res.to_gpr;

	// --------------------
	// HI/LO pair
	always_ff @(posedge clk)
	begin
		if (rst)
			hilo_q <= '0;
		else if (res.valid && !res.to_gpr)
			hilo_q <= res.value;              // Multiply, accumulate or divide
		else if (req.valid && req.op == MD_MTHI)
			hilo_q[2*W-1:W] <= req.a;
		else if (req.valid && req.op == MD_MTLO)
			hilo_q[W-1:0] <= req.a;
	end

	// --------------------
	// General register write port
	always_ff @(posedge clk)
	begin
		if (rst)
			we_q <= 1'b0;
		else
			we_q <= mul_to_gpr || is_mfhi || is_mflo;
	end

	always_ff @(posedge clk)
	begin
		if (mul_to_gpr)
			data_q <= res.value[W-1:0];       // MUL keeps the low word only
		else if (is_mfhi)
			data_q <= hilo_q[2*W-1:W];
		else if (is_mflo)
			data_q <= hilo_q[W-1:0];
	end

	assign hilo     = hilo_q;
	assign gpr_we   = we_q;
	assign gpr_data = data_q;

endmodule

// ==== src/md_unit.sv ====
module md_unit import muldiv_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   flush,
	input  logic   instr_valid,
	input  word_t  instr,
	input  word_t  rs_data,
	input  word_t  rt_data,
	output logic   busy,
	output logic   gpr_we,
	output word_t  gpr_data,
	output dword_t hilo
);

	md_req_t req;    // Decoded request
	md_res_t res;    // Arithmetic result on its way to HI/LO

	md_decode md_decode_i (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.busy        (busy),
		.req         (req)
	);

	md_execute md_execute_i (
		.clk   (clk),
		.rst   (rst),
		.flush (flush),
		.req   (req),
		.hilo  (hilo),
		.res   (res),
		.busy  (busy)
	);

	// Moves bypass execute and go straight to the HI/LO stage
	md_hilo md_hilo_i (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.res      (res),
		.hilo     (hilo),
		.gpr_we   (gpr_we),
		.gpr_data (gpr_data)
	);

endmodule

// ==== tb/md_unit_tb.sv ====
`include "muldiv_macros.svh"

module md_unit_tb import muldiv_pkg::*; ;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_RAND    = 8;
	localparam int N_ACC     = 6;
	localparam int N_MUL     = 10;
	localparam int N_DIV_DIR = 6;
	localparam int MAX_WAIT  = `MD_DIV_CYC + 8;  // Longest legal busy stretch plus margin
	localparam int N_OPS     = 1 + (16 + N_RAND) * 2 * 3 + 4 * N_ACC * 3 + 2 + N_MUL
		+ (N_DIV_DIR + N_RAND) * 2 + 5;

	logic   clk = 1'b0;
	logic   rst;
	logic   flush;
	logic   instr_valid;
	word_t  instr;
	word_t  rs_data;
	word_t  rt_data;
	logic   busy;
	logic   gpr_we;
	word_t  gpr_data;
	dword_t hilo;

	dword_t                  model_hilo;
	logic [2*`MD_WORD_W:0]   exp_q[$];    // Top bit selects gpr_data, else hilo
	logic [2*`MD_WORD_W:0]   pending;
	int                      seed = 32'h1c914098;
	int                      errors;
	int                      checks;
	int                      errors0;
	int                      checks0;
	string                   test_name;
	word_t                   corners [4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
	md_op_t                  acc_ops [4] = '{MD_MADD, MD_MADDU, MD_MSUB, MD_MSUBU};
	word_t                   div_a [N_DIV_DIR] = '{32'd100, 32'd100, -32'sd100, -32'sd100,
		32'h8000_0000, 32'd5};
	word_t                   div_b [N_DIV_DIR] = '{32'd7, -32'sd7, 32'd7, -32'sd7,
		32'hffff_ffff, 32'd9};

	md_unit md_unit_i (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.busy        (busy),
		.gpr_we      (gpr_we),
		.gpr_data    (gpr_data),
		.hilo        (hilo)
	);

	always #50 clk = ~clk;

	// --------------------
	// Expected values, straight from the architecture rules
	function automatic dword_t ref_result(input md_op_t op, input word_t a, input word_t b,
		input dword_t cur);
		longint sa;
		longint sb;
		dword_t sprod;
		dword_t uprod;
		sa    = longint'($signed(a));
		sb    = longint'($signed(b));
		sprod = dword_t'(sa * sb);
		uprod = {32'b0, a} * {32'b0, b};
		case (op)
			MD_MULT:  return sprod;
			MD_MULTU: return uprod;
			MD_MADD:  return cur + sprod;
			MD_MADDU: return cur + uprod;
			MD_MSUB:  return cur - sprod;
			MD_MSUBU: return cur - uprod;
			MD_MUL:   return {32'b0, sprod[31:0]};
			MD_DIV:   return {word_t'(sa % sb), word_t'(sa / sb)};  // Truncates toward zero
			MD_DIVU:  return {a % b, a / b};
			MD_MTHI:  return {a, cur[31:0]};
			MD_MTLO:  return {cur[63:32], a};
			MD_MFHI:  return {32'b0, cur[63:32]};
			MD_MFLO:  return {32'b0, cur[31:0]};
			default:  return cur;
		endcase
	endfunction

	// R-type word with rs=4, rt=5, rd=2
	function automatic word_t encode(input md_op_t op);
		logic [5:0] opc;
		logic [5:0] fn;
		opc = (op inside {MD_MADD, MD_MADDU, MD_MUL, MD_MSUB, MD_MSUBU}) ? 6'h1c : 6'h00;
		case (op)
			MD_MFHI:  fn = 6'h10;
			MD_MTHI:  fn = 6'h11;
			MD_MFLO:  fn = 6'h12;
			MD_MTLO:  fn = 6'h13;
			MD_MULT:  fn = 6'h18;
			MD_MULTU: fn = 6'h19;
			MD_DIV:   fn = 6'h1a;
			MD_DIVU:  fn = 6'h1b;
			MD_MADD:  fn = 6'h00;
			MD_MADDU: fn = 6'h01;
			MD_MUL:   fn = 6'h02;
			MD_MSUB:  fn = 6'h04;
			MD_MSUBU: fn = 6'h05;
			default:  fn = 6'h3f;
		endcase
		return {opc, 5'd4, 5'd5, 5'd2, 5'd0, fn};
	endfunction

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	// --------------------
	// Stimulus helpers, all return 5 ns after a rising edge
	task automatic tick();
		@(posedge clk);
		#5;
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (busy && waited < MAX_WAIT)
		begin
			tick();
			waited++;
		end
		if (busy)
		begin
			$display("Timeout: busy still high after %0d cycles in test %s", MAX_WAIT, test_name);
			errors++;
		end
	endtask

	task automatic wait_gpr_write();
		int waited;
		waited = 0;
		while (!gpr_we && waited < MAX_WAIT)
		begin
			tick();
			waited++;
		end
		if (!gpr_we)
		begin
			$display("Timeout: no register write seen in test %s", test_name);
			errors++;
		end
	endtask

	task automatic issue(input word_t word, input word_t a, input word_t b);
		wait_idle();
		instr_valid = 1'b1;
		instr       = word;
		rs_data     = a;
		rt_data     = b;
		tick();
		instr_valid = 1'b0;
	endtask

	task automatic run_op(input md_op_t op, input word_t a, input word_t b);
		dword_t expect_val;
		expect_val = ref_result(op, a, b, model_hilo);
		issue(encode(op), a, b);
		if (op inside {MD_MUL, MD_MFHI, MD_MFLO})
		begin
			wait_gpr_write();
			exp_q.push_back({1'b1, expect_val});
			exp_q.push_back({1'b0, model_hilo});  // Register writes leave HI/LO alone
		end
		else
		begin
			if (!(op inside {MD_MTHI, MD_MTLO}))
				wait_idle();
			tick();                                // HI/LO takes the value on this edge
			model_hilo = expect_val;
			exp_q.push_back({1'b0, expect_val});
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors0   = errors;
		checks0   = checks;
	endtask

	task automatic end_test();
		while (exp_q.size() != 0)
			tick();
		$display("Test %-10s %4d checks, %0d errors", test_name, checks - checks0,
			errors - errors0);
	endtask

	// --------------------
	// Comparison, at the falling edge where outputs are settled
	always @(negedge clk)
	begin
		while (exp_q.size() != 0)
		begin
			pending = exp_q.pop_front();
			checks++;
			if (pending[2*`MD_WORD_W])
				assert (gpr_data === pending[31:0])
				else
				begin
					$display("Error at %0t: %s gpr_data is %h, expected %h", $time, test_name,
						gpr_data, pending[31:0]);
					errors++;
				end
			else
				assert (hilo === pending[63:0])
				else
				begin
					$display("Error at %0t: %s hilo is %h, expected %h", $time, test_name,
						hilo, pending[63:0]);
					errors++;
				end
		end
	end

	initial
	begin
		repeat (N_OPS * 40 + 20) @(posedge clk);
		$display("Watchdog expired after %0d clock periods", N_OPS * 40 + 20);
		$display("Done: errors found");
		$finish;
	end

	// --------------------
	initial
	begin
		word_t a;
		word_t b;
		word_t r;
		rst         = 1'b1;
		flush       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		rs_data     = '0;
		rt_data     = '0;
		model_hilo  = '0;
		errors      = 0;
		checks      = 0;
		repeat (3) @(posedge clk);
		#5;
		rst = 1'b0;

		begin_test("reset");
		assert (busy === 1'b0 && gpr_we === 1'b0)
		else
		begin
			$display("Error at %0t: busy %b gpr_we %b after reset", $time, busy, gpr_we);
			errors++;
		end
		exp_q.push_back({1'b0, 64'h0});
		end_test();

		begin_test("mult");
		for (int k = 0; k < 2; k++)
			for (int i = 0; i < 16 + N_RAND; i++)
			begin
				a = (i < 16) ? corners[i / 4] : rand_word();
				b = (i < 16) ? corners[i % 4] : rand_word();
				run_op(k == 0 ? MD_MULT : MD_MULTU, a, b);
				run_op(MD_MFHI, 0, 0);
				run_op(MD_MFLO, 0, 0);
			end
		end_test();

		begin_test("accumulate");
		for (int k = 0; k < 4; k++)
			for (int i = 0; i < N_ACC; i++)
			begin
				run_op(MD_MTHI, rand_word(), 0);
				run_op(MD_MTLO, rand_word(), 0);
				a = (i == 0) ? 32'h8000_0000 : rand_word();
				b = (i == 0) ? 32'hffff_ffff : rand_word();
				run_op(acc_ops[k], a, b);
			end
		end_test();

		begin_test("mul");
		run_op(MD_MTHI, rand_word(), 0);
		run_op(MD_MTLO, rand_word(), 0);
		run_op(MD_MUL, 32'h8000_0000, 32'hffff_ffff);
		for (int i = 1; i < N_MUL; i++)
			run_op(MD_MUL, rand_word(), rand_word());
		end_test();

		begin_test("divide");
		for (int k = 0; k < 2; k++)
			for (int i = 0; i < N_DIV_DIR + N_RAND; i++)
			begin
				r = rand_word();
				a = (i < N_DIV_DIR) ? div_a[i] : rand_word();
				b = (i < N_DIV_DIR) ? div_b[i] : ((i % 2) ? r : {{16{r[31]}}, r[15:0]});
				if (b == 0)
					b = 1;
				run_op(k == 0 ? MD_DIV : MD_DIVU, a, b);
			end
		end_test();

		begin_test("flush");
		run_op(MD_MTHI, 32'h1234_5678, 0);
		run_op(MD_MTLO, 32'h9abc_def0, 0);
		issue(encode(MD_DIV), 32'd1000, 32'd7);
		repeat (10) tick();    // Divider halfway through its steps
		flush = 1'b1;
		tick();
		flush = 1'b0;
		assert (busy === 1'b0)
		else
		begin
			$display("Error at %0t: busy is %b after flush", $time, busy);
			errors++;
		end
		repeat (`MD_DIV_CYC + 4) tick();
		exp_q.push_back({1'b0, model_hilo});
		run_op(MD_MULT, rand_word(), rand_word());
		end_test();

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+src
src/muldiv_pkg.sv
src/md_decode.sv
src/md_divider.sv
src/md_execute.sv
src/md_hilo.sv
src/md_unit.sv
tb/md_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= md_unit_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
